//--- logic/dnsz_aw_planner.sv
`timescale 1ns/1ps
`include "dnsz_defs.svh"

module dnsz_aw_planner (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  dnsz_pkg::aw_req_t      wide_aw,
  input  logic                   wide_aw_valid,
  output logic                   wide_aw_ready,
  output dnsz_pkg::aw_req_t      narrow_aw,
  output logic                   narrow_aw_valid,
  input  logic                   narrow_aw_ready,
  output dnsz_pkg::burst_plan_t  plan,
  output logic                   plan_valid,
  input  logic                   plan_ready,
  input  logic                   burst_done
);

  localparam int unsigned nb_log = $clog2(`DNSZ_NARROW_DW / 8);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_plan,
    st_busy
  } state_e;

  state_e                state_q;
  logic                  downsize;
  dnsz_pkg::addr_t       size_mask;
  dnsz_pkg::addr_t       align_adj;
  dnsz_pkg::addr_t       full_len;
  dnsz_pkg::aw_req_t     narrow_d;
  dnsz_pkg::aw_req_t     narrow_q;
  dnsz_pkg::burst_plan_t plan_q;

  // ------------------------------
  // Narrow burst computation
  // ------------------------------

  assign downsize = (wide_aw.burst == dnsz_pkg::BURST_INCR) &&
                    (|(wide_aw.cache & dnsz_pkg::CACHE_MODIFIABLE)) &&
                    (wide_aw.size > 3'(nb_log));

  // Whole narrow words skipped inside the first beat
  assign size_mask = (dnsz_pkg::addr_t'(1) << wide_aw.size) - 1'b1;
  assign align_adj = (wide_aw.addr & size_mask) >> nb_log;

  // Ratio is a power of two, so (len+1)*ratio is a shift
  assign full_len = ((dnsz_pkg::addr_t'(wide_aw.len) + 1'b1) << (wide_aw.size - 3'(nb_log)))
                    - align_adj - 1'b1;

  always_comb begin
    narrow_d = wide_aw;
    if (downsize) begin
      narrow_d.size = 3'(nb_log);
      narrow_d.len  = (full_len > `DNSZ_MAX_NLEN) ? 8'(`DNSZ_MAX_NLEN) : full_len[7:0];
    end
  end

  // ------------------------------
  // Sequencing
  // ------------------------------

  assign wide_aw_ready   = (state_q == st_idle);
  assign narrow_aw_valid = (state_q == st_addr);
  assign plan_valid      = (state_q == st_plan);
  assign narrow_aw       = narrow_q;
  assign plan            = plan_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: if (wide_aw_valid) state_q <= st_addr;
        st_addr: if (narrow_aw_ready) state_q <= st_plan;
        st_plan: if (plan_ready) state_q <= st_busy;
        default: if (burst_done) state_q <= st_idle;
      endcase
    end
  end

  // Request and plan are captured together on acceptance
  always_ff @(posedge clk_i) begin
    if (wide_aw_valid && wide_aw_ready) begin
      narrow_q        <= narrow_d;
      plan_q.addr     <= wide_aw.addr;
      plan_q.size     <= wide_aw.size;
      plan_q.nlen     <= downsize ? full_len[8:0] : {1'b0, wide_aw.len};
      plan_q.downsize <= downsize;
    end
  end

endmodule

//--- logic/dnsz_defs.svh
`ifndef DNSZ_DEFS_SVH
`define DNSZ_DEFS_SVH

// Data widths on the two sides of the converter
`define DNSZ_WIDE_DW   64
`define DNSZ_NARROW_DW 32

// Request field widths
`define DNSZ_AW   32
`define DNSZ_ID_W 4

// Largest len value one narrow burst can carry.
// Longer downsized bursts are not split.
`define DNSZ_MAX_NLEN 255

`endif

//--- logic/dnsz_lane_serializer.sv
`timescale 1ns/1ps
`include "dnsz_defs.svh"

module dnsz_lane_serializer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  dnsz_pkg::burst_plan_t  plan,
  input  logic                   plan_valid,
  output logic                   plan_ready,
  input  dnsz_pkg::wide_beat_t   beat,
  input  logic                   beat_valid,
  output logic                   beat_ready,
  output dnsz_pkg::narrow_beat_t narrow_w,
  output logic                   narrow_w_valid,
  input  logic                   narrow_w_ready,
  output logic                   burst_done
);

  localparam int unsigned nb     = `DNSZ_NARROW_DW / 8;
  localparam int unsigned nb_log = $clog2(nb);
  localparam int unsigned wb_log = $clog2(`DNSZ_WIDE_DW / 8);

  typedef logic [nb_log:0] lane_cnt_t;

  logic               held_q;
  logic [8:0]         rem_q;
  dnsz_pkg::addr_t    addr_q;
  logic [2:0]         osize_q;
  logic               downsize_q;
  logic [2:0]         nsize;
  dnsz_pkg::addr_t    nsize_mask;
  dnsz_pkg::addr_t    osize_mask;
  dnsz_pkg::addr_t    addr_next;
  logic [wb_log-1:0]  off_w;
  logic [nb_log-1:0]  off_n;
  lane_cnt_t          span;
  lane_cnt_t          lanes;
  logic [nb-1:0][7:0] n_bytes;
  logic [nb-1:0]      n_strb;
  logic               xfer;
  logic               window_done;

  // ------------------------------
  // Lane steering
  // ------------------------------

  // Downsized bursts run at full narrow size
  assign nsize = downsize_q ? 3'(nb_log) : osize_q;
  assign off_w = addr_q[wb_log-1:0];
  assign off_n = addr_q[nb_log-1:0];

  assign span  = (nsize >= 3'(nb_log)) ? lane_cnt_t'(nb) : lane_cnt_t'(1) << nsize;
  assign lanes = (span < lane_cnt_t'(nb) - off_n) ? span : lane_cnt_t'(nb) - off_n;

  always_comb begin
    n_bytes = '0;
    n_strb  = '0;
    if (lanes == lane_cnt_t'(nb)) begin
      // Whole narrow word, pick it from the word view
      n_bytes = beat.data.words[off_w[wb_log-1:nb_log]];
      n_strb  = beat.strb[off_w[wb_log-1:nb_log]*nb +: nb];
    end else begin
      for (int k = 0; k < nb; k++) begin
        if (lane_cnt_t'(k) < lanes) begin
          n_bytes[off_n + k] = beat.data.bytes[off_w + k];
          n_strb[off_n + k]  = beat.strb[off_w + k];
        end
      end
    end
  end

  always_comb begin
    narrow_w.data = n_bytes;
    narrow_w.strb = n_strb;
    narrow_w.last = (rem_q == '0);
  end

  // ------------------------------
  // Handshakes and progress
  // ------------------------------

  assign plan_ready     = ~held_q;
  assign narrow_w_valid = held_q & beat_valid;
  assign xfer           = narrow_w_valid & narrow_w_ready;

  // Step to the next narrow-size boundary
  assign nsize_mask = (dnsz_pkg::addr_t'(1) << nsize) - 1'b1;
  assign addr_next  = (addr_q & ~nsize_mask) + (dnsz_pkg::addr_t'(1) << nsize);

  // Wide beat is used up once the original-size window is left
  assign osize_mask  = (dnsz_pkg::addr_t'(1) << osize_q) - 1'b1;
  assign window_done = (addr_next & ~osize_mask) != (addr_q & ~osize_mask);

  assign beat_ready = xfer & (narrow_w.last | window_done);
  assign burst_done = xfer & narrow_w.last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
      rem_q  <= '0;
    end else if (plan_valid && plan_ready) begin
      held_q <= 1'b1;
      rem_q  <= plan.nlen;
    end else if (xfer) begin
      held_q <= ~narrow_w.last;
      rem_q  <= rem_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (plan_valid && plan_ready) begin
      addr_q     <= plan.addr;
      osize_q    <= plan.size;
      downsize_q <= plan.downsize;
    end else if (xfer) begin
      addr_q <= addr_next;
    end
  end

endmodule

//--- logic/dnsz_pkg.sv
`include "dnsz_defs.svh"

package dnsz_pkg;

  typedef logic [`DNSZ_AW-1:0]   addr_t;
  typedef logic [`DNSZ_ID_W-1:0] id_t;
  typedef logic [1:0]            burst_t;

  localparam burst_t     BURST_INCR       = 2'b01;
  localparam logic [3:0] CACHE_MODIFIABLE = 4'b0010;

  // Write address request, same layout on both sides
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    burst_t     burst;
    logic [3:0] cache;
  } aw_req_t;

  // What the serializer needs to walk one burst
  typedef struct packed {
    addr_t      addr;
    logic [2:0] size;
    logic [8:0] nlen;
    logic       downsize;
  } burst_plan_t;

  // Wide data word, seen as byte lanes or as narrow words
  typedef union packed {
    logic [`DNSZ_WIDE_DW/8-1:0][7:0]                            bytes;
    logic [`DNSZ_WIDE_DW/`DNSZ_NARROW_DW-1:0][`DNSZ_NARROW_DW-1:0] words;
  } wide_word_u;

  typedef struct packed {
    wide_word_u                 data;
    logic [`DNSZ_WIDE_DW/8-1:0] strb;
    logic                       last;
  } wide_beat_t;

  typedef struct packed {
    logic [`DNSZ_NARROW_DW-1:0]   data;
    logic [`DNSZ_NARROW_DW/8-1:0] strb;
    logic                         last;
  } narrow_beat_t;

  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } b_resp_t;

endpackage

//--- logic/dnsz_wide_beat_buf.sv
`timescale 1ns/1ps
`include "dnsz_defs.svh"

module dnsz_wide_beat_buf (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  dnsz_pkg::wide_beat_t  in_beat,
  input  logic                  in_valid,
  output logic                  in_ready,
  output dnsz_pkg::wide_beat_t  beat,
  output logic                  beat_valid,
  input  logic                  beat_ready
);

  logic                 full_q;
  logic                 armed_q;
  dnsz_pkg::wide_beat_t beat_q;

  // Space when empty, or when the held beat leaves this cycle
  assign in_ready   = armed_q & (~full_q | beat_ready);
  assign beat_valid = full_q;
  assign beat       = beat_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q  <= 1'b0;
      armed_q <= 1'b0;
    end else begin
      // Wide W port opens one cycle out of reset
      armed_q <= 1'b1;
      if (in_ready) full_q <= in_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid && in_ready) beat_q <= in_beat;
  end

endmodule

//--- logic/dnsz_write_top.sv
`timescale 1ns/1ps
`include "dnsz_defs.svh"

module dnsz_write_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Wide side
  input  dnsz_pkg::aw_req_t      wide_aw,
  input  logic                   wide_aw_valid,
  output logic                   wide_aw_ready,
  input  dnsz_pkg::wide_beat_t   wide_w,
  input  logic                   wide_w_valid,
  output logic                   wide_w_ready,
  output dnsz_pkg::b_resp_t      wide_b,
  output logic                   wide_b_valid,
  input  logic                   wide_b_ready,
  // Narrow side
  output dnsz_pkg::aw_req_t      narrow_aw,
  output logic                   narrow_aw_valid,
  input  logic                   narrow_aw_ready,
  output dnsz_pkg::narrow_beat_t narrow_w,
  output logic                   narrow_w_valid,
  input  logic                   narrow_w_ready,
  input  dnsz_pkg::b_resp_t      narrow_b,
  input  logic                   narrow_b_valid,
  output logic                   narrow_b_ready
);

  dnsz_pkg::burst_plan_t plan;
  logic                  plan_valid;
  logic                  plan_ready;
  dnsz_pkg::wide_beat_t  beat;
  logic                  beat_valid;
  logic                  beat_ready;
  logic                  burst_done;

  dnsz_aw_planner u_planner (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wide_aw        (wide_aw),
    .wide_aw_valid  (wide_aw_valid),
    .wide_aw_ready  (wide_aw_ready),
    .narrow_aw      (narrow_aw),
    .narrow_aw_valid(narrow_aw_valid),
    .narrow_aw_ready(narrow_aw_ready),
    .plan           (plan),
    .plan_valid     (plan_valid),
    .plan_ready     (plan_ready),
    .burst_done     (burst_done)
  );

  dnsz_wide_beat_buf u_beat_buf (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .in_beat   (wide_w),
    .in_valid  (wide_w_valid),
    .in_ready  (wide_w_ready),
    .beat      (beat),
    .beat_valid(beat_valid),
    .beat_ready(beat_ready)
  );

  dnsz_lane_serializer u_serializer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .plan          (plan),
    .plan_valid    (plan_valid),
    .plan_ready    (plan_ready),
    .beat          (beat),
    .beat_valid    (beat_valid),
    .beat_ready    (beat_ready),
    .narrow_w      (narrow_w),
    .narrow_w_valid(narrow_w_valid),
    .narrow_w_ready(narrow_w_ready),
    .burst_done    (burst_done)
  );

  // Write responses, no latency
  assign wide_b         = narrow_b;
  assign wide_b_valid   = narrow_b_valid;
  assign narrow_b_ready = wide_b_ready;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the downsizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dnsz_tb \
  -f sources.f -Mdir "$build_dir" -o dnsz_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/dnsz_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$log"; then
  exit 1
fi
if ! grep -q "Simulation completed successfully" "$log"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

//--- sources.f
+incdir+logic
logic/dnsz_pkg.sv
logic/dnsz_aw_planner.sv
logic/dnsz_wide_beat_buf.sv
logic/dnsz_lane_serializer.sv
logic/dnsz_write_top.sv
verif/dnsz_asserts.sv
verif/dnsz_tb.sv

//--- verif/dnsz_asserts.sv
`timescale 1ns/1ps
`include "dnsz_defs.svh"

module dnsz_asserts (
  input logic                   clk_i,
  input logic                   rst_ni,
  input dnsz_pkg::aw_req_t      narrow_aw,
  input logic                   narrow_aw_valid,
  input logic                   narrow_aw_ready,
  input dnsz_pkg::narrow_beat_t narrow_w,
  input logic                   narrow_w_valid,
  input logic                   narrow_w_ready
);

  logic open_q;

  // Burst open from narrow request transfer to its last beat
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      open_q <= 1'b0;
    end else if (narrow_aw_valid && narrow_aw_ready) begin
      open_q <= 1'b1;
    end else if (narrow_w_valid && narrow_w_ready && narrow_w.last) begin
      open_q <= 1'b0;
    end
  end

  // ------------------------------
  // Handshake stability
  // ------------------------------

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    narrow_aw_valid && !narrow_aw_ready |=> narrow_aw_valid && $stable(narrow_aw))
    else $error("narrow request dropped or changed before its transfer");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    narrow_w_valid && !narrow_w_ready |=> narrow_w_valid && $stable(narrow_w))
    else $error("narrow beat dropped or changed before its transfer");

  // ------------------------------
  // Burst framing
  // ------------------------------

  w_after_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    narrow_w_valid |-> open_q)
    else $error("narrow beat offered before its narrow request transfer");

  // A new request only once the previous burst saw its last
  one_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    narrow_aw_valid && narrow_aw_ready |-> !open_q)
    else $error("new narrow request while the previous burst had no last beat");

endmodule

bind dnsz_write_top dnsz_asserts u_asserts (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .narrow_aw      (narrow_aw),
  .narrow_aw_valid(narrow_aw_valid),
  .narrow_aw_ready(narrow_aw_ready),
  .narrow_w       (narrow_w),
  .narrow_w_valid (narrow_w_valid),
  .narrow_w_ready (narrow_w_ready)
);

//--- verif/dnsz_tb.sv
`timescale 1ns/1ps
`include "dnsz_defs.svh"

module dnsz_tb;

  localparam int unsigned narrow_bytes = `DNSZ_NARROW_DW / 8;
  localparam int unsigned wide_bytes   = `DNSZ_WIDE_DW / 8;
  // Narrow beats over all bursts issued below
  localparam int total_nbeats   = 53;
  localparam int timeout_cycles = total_nbeats * 4 + 200;

  logic                   clk_i;
  logic                   rst_ni;
  dnsz_pkg::aw_req_t      wide_aw;
  logic                   wide_aw_valid;
  logic                   wide_aw_ready;
  dnsz_pkg::wide_beat_t   wide_w;
  logic                   wide_w_valid;
  logic                   wide_w_ready;
  dnsz_pkg::b_resp_t      wide_b;
  logic                   wide_b_valid;
  logic                   wide_b_ready;
  dnsz_pkg::aw_req_t      narrow_aw;
  logic                   narrow_aw_valid;
  logic                   narrow_aw_ready;
  dnsz_pkg::narrow_beat_t narrow_w;
  logic                   narrow_w_valid;
  logic                   narrow_w_ready;
  dnsz_pkg::b_resp_t      narrow_b;
  logic                   narrow_b_valid;
  logic                   narrow_b_ready;

  logic [15:0]            lfsr;
  int                     cycles;
  int                     tests;
  int                     checks;
  int                     errors;
  dnsz_pkg::wide_beat_t   wbeats[$];
  dnsz_pkg::narrow_beat_t exp_w[$];
  dnsz_pkg::aw_req_t      exp_aw;

  dnsz_write_top u_dnsz_write_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .wide_aw        (wide_aw),
    .wide_aw_valid  (wide_aw_valid),
    .wide_aw_ready  (wide_aw_ready),
    .wide_w         (wide_w),
    .wide_w_valid   (wide_w_valid),
    .wide_w_ready   (wide_w_ready),
    .wide_b         (wide_b),
    .wide_b_valid   (wide_b_valid),
    .wide_b_ready   (wide_b_ready),
    .narrow_aw      (narrow_aw),
    .narrow_aw_valid(narrow_aw_valid),
    .narrow_aw_ready(narrow_aw_ready),
    .narrow_w       (narrow_w),
    .narrow_w_valid (narrow_w_valid),
    .narrow_w_ready (narrow_w_ready),
    .narrow_b       (narrow_b),
    .narrow_b_valid (narrow_b_valid),
    .narrow_b_ready (narrow_b_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ------------------------------
  // Random bits and checking
  // ------------------------------

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string what, input logic [72:0] exp, input logic [72:0] act);
    checks++;
    assert (act === exp) else begin
      $display("mismatch %s: expected %h actual %h", what, exp, act);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("test %s: %0d errors", name, errors - errs_before);
  endtask

  function automatic dnsz_pkg::aw_req_t make_req(input logic [3:0] id, input logic [31:0] addr,
      input logic [7:0] len, input logic [2:0] size, input logic [1:0] burst,
      input logic [3:0] cache);
    dnsz_pkg::aw_req_t r;
    r.id    = id;
    r.addr  = addr;
    r.len   = len;
    r.size  = size;
    r.burst = burst;
    r.cache = cache;
    return r;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------

  function automatic void build_expected(input dnsz_pkg::aw_req_t req);
    logic                   down;
    int unsigned            beat_bytes;
    int unsigned            count;
    int unsigned            step;
    int unsigned            lanes;
    int unsigned            addr;
    int unsigned            next;
    int unsigned            wi;
    int unsigned            on;
    int unsigned            ow;
    dnsz_pkg::narrow_beat_t nb;
    down = (req.burst == dnsz_pkg::BURST_INCR) &&
           ((req.cache & dnsz_pkg::CACHE_MODIFIABLE) != 0) && (req.size > 3'd2);
    beat_bytes = 1 << req.size;
    exp_aw = req;
    count = req.len + 1;
    if (down) begin
      // Whole narrow words skipped in the first beat come off the count
      count = count * (beat_bytes / narrow_bytes) - (req.addr % beat_bytes) / narrow_bytes;
      exp_aw.len  = count - 1;
      exp_aw.size = 3'd2;
    end
    step = down ? narrow_bytes : beat_bytes;
    addr = req.addr;
    wi = 0;
    for (int unsigned i = 0; i < count; i++) begin
      on = addr % narrow_bytes;
      ow = addr % wide_bytes;
      lanes = (step < narrow_bytes) ? step : narrow_bytes;
      if (lanes > narrow_bytes - on) lanes = narrow_bytes - on;
      nb = '0;
      for (int unsigned k = 0; k < lanes; k++) begin
        nb.data[8*(on+k) +: 8] = wbeats[wi].data.bytes[ow+k];
        nb.strb[on+k]          = wbeats[wi].strb[ow+k];
      end
      nb.last = (i == count - 1);
      exp_w.push_back(nb);
      next = addr - addr % step + step;
      if (next / beat_bytes != addr / beat_bytes) wi++;
      addr = next;
    end
  endfunction

  // ------------------------------
  // Channel drivers
  // ------------------------------

  task automatic send_request(input dnsz_pkg::aw_req_t req);
    @(negedge clk_i);
    wide_aw       = req;
    wide_aw_valid = 1'b1;
    #1;
    while (!wide_aw_ready) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    wide_aw_valid = 1'b0;
  endtask

  task automatic send_beats();
    foreach (wbeats[i]) begin
      @(negedge clk_i);
      wide_w       = wbeats[i];
      wide_w_valid = 1'b1;
      #1;
      while (!wide_w_ready) begin
        @(negedge clk_i);
        #1;
      end
    end
    @(negedge clk_i);
    wide_w_valid = 1'b0;
  endtask

  task automatic take_request(input string name, input logic stall);
    @(negedge clk_i);
    narrow_aw_ready = !stall;
    #1;
    while (!narrow_aw_valid) begin
      @(negedge clk_i);
      #1;
    end
    if (stall) begin
      repeat (2) @(negedge clk_i);
      narrow_aw_ready = 1'b1;
      #1;
    end
    check_value({name, " request"}, exp_aw, narrow_aw);
    @(negedge clk_i);
  endtask

  task automatic take_beats(input string name, input logic stall);
    logic [63:0] bits;
    int          idx;
    idx = 0;
    while (idx < exp_w.size()) begin
      @(negedge clk_i);
      take_bits(stall ? 1 : 0, bits);
      narrow_w_ready = stall ? bits[0] : 1'b1;
      #1;
      if (narrow_w_valid && narrow_w_ready) begin
        check_value($sformatf("%s beat %0d", name, idx), exp_w[idx], narrow_w);
        idx++;
      end
    end
  endtask

  task automatic run_burst(input string name, input dnsz_pkg::aw_req_t req, input logic stall);
    dnsz_pkg::wide_beat_t wb;
    logic [63:0]          bits;
    int                   errs_before;
    errs_before = errors;
    wbeats.delete();
    exp_w.delete();
    for (int i = 0; i <= req.len; i++) begin
      take_bits(64, bits);
      wb.data.bytes = bits;
      take_bits(8, bits);
      wb.strb = bits[7:0];
      wb.last = (i == req.len);
      wbeats.push_back(wb);
    end
    build_expected(req);
    fork
      send_request(req);
      send_beats();
      take_request(name, stall);
      take_beats(name, stall);
    join
    // Planner takes a new request once the last beat is out
    @(negedge clk_i);
    #1;
    check_value({name, " ready after last"}, 1'b1, wide_aw_ready);
    report_test(name, errs_before);
  endtask

  task automatic run_responses();
    logic [63:0] bits;
    int          errs_before;
    errs_before = errors;
    for (int i = 0; i < 6; i++) begin
      take_bits(8, bits);
      @(negedge clk_i);
      narrow_b       = bits[5:0];
      narrow_b_valid = bits[6];
      wide_b_ready   = bits[7];
      #1;
      check_value("response payload", bits[5:0], wide_b);
      check_value("response valid", bits[6], wide_b_valid);
      check_value("response ready", bits[7], narrow_b_ready);
    end
    @(negedge clk_i);
    narrow_b_valid = 1'b0;
    wide_b_ready   = 1'b0;
    report_test("response_passthrough", errs_before);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin : watchdog
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout after %0d cycles, a handshake never completed", cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int errs_before;
    lfsr            = 16'd55236;
    tests           = 0;
    checks          = 0;
    errors          = 0;
    rst_ni          = 1'b0;
    wide_aw         = '0;
    wide_aw_valid   = 1'b0;
    wide_w          = '0;
    wide_w_valid    = 1'b0;
    wide_b_ready    = 1'b0;
    narrow_aw_ready = 1'b1;
    narrow_w_ready  = 1'b1;
    narrow_b        = '0;
    narrow_b_valid  = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    errs_before = errors;
    check_value("reset narrow request valid", 1'b0, narrow_aw_valid);
    check_value("reset narrow beat valid", 1'b0, narrow_w_valid);
    check_value("reset response valid", 1'b0, wide_b_valid);
    check_value("reset request ready", 1'b1, wide_aw_ready);
    check_value("reset beat ready", 1'b0, wide_w_ready);
    report_test("reset", errs_before);
    @(negedge clk_i);
    rst_ni = 1'b1;

    run_burst("passthrough_size2", make_req(4'h1, 32'h100, 8'd3, 3'd2, 2'b01, 4'h2), 1'b0);
    run_burst("downsize_aligned", make_req(4'h2, 32'h200, 8'd3, 3'd3, 2'b01, 4'h3), 1'b0);
    run_burst("downsize_unaligned", make_req(4'h3, 32'h104, 8'd1, 3'd3, 2'b01, 4'h2), 1'b0);
    // Random narrow back-pressure
    run_burst("stall_downsize_long", make_req(4'h4, 32'h300, 8'd7, 3'd3, 2'b01, 4'h2), 1'b1);
    run_burst("stall_downsize_offset", make_req(4'h5, 32'h404, 8'd4, 3'd3, 2'b01, 4'hf),
              1'b1);
    run_burst("stall_size1", make_req(4'h6, 32'h502, 8'd5, 3'd1, 2'b01, 4'h2), 1'b1);
    run_burst("stall_fixed_size0", make_req(4'h7, 32'h603, 8'd3, 3'd0, 2'b00, 4'h2), 1'b1);
    run_burst("non_modifiable", make_req(4'h8, 32'h700, 8'd2, 3'd3, 2'b01, 4'h0), 1'b0);
    run_responses();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
